// ==== files.f ====
nn_pkg.sv
input_buffer.sv
weight_rom.sv
mac_lane.sv
fc_control.sv
fc_layer.sv
fc_layer_assert.sv
tb_fc_layer.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fc_layer testbench, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_fc_layer -f files.f \
	-o sim_fc_layer > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_fc_layer > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "No errors" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"

// ==== tb_fc_layer.sv ====
`timescale 1ns/1ps

module tb_fc_layer;

	typedef nn_pkg::data_t vec_t [nn_pkg::num_inputs];

	localparam int wait_limit = 2000;

	logic clk;
	logic reset;
	logic input_valid;
	logic input_ready;
	nn_pkg::data_t input_data;
	logic output_valid;
	logic output_ready;
	nn_pkg::data_t output_data;

	int seed = 32'hce81;
	int ready_seed = 32'hce81;
	bit stall_mode = 1'b0;
	string test_name = "reset";
	int out_count = 0;
	nn_pkg::data_t expected_q [$];

	fc_layer i_fc_layer (
		.clk(clk),
		.reset(reset),
		.input_valid(input_valid),
		.input_ready(input_ready),
		.input_data(input_data),
		.output_valid(output_valid),
		.output_ready(output_ready),
		.output_data(output_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_with(input string line);
		$display("%s", line);
		$display("Errors found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_data(input nn_pkg::data_t expected, input nn_pkg::data_t actual,
		input string name);
		if (actual !== expected) begin
			fail_with($sformatf("ERR %s expected %0d actual %0d", name, expected, actual));
		end
	endtask

	task automatic check_flag(input logic expected, input logic actual, input string name);
		if (actual !== expected) begin
			fail_with($sformatf("ERR %s expected %0b actual %0b", name, expected, actual));
		end
	endtask

	// Dot product of one weight row, then ReLU and clip to 32767
	function automatic nn_pkg::data_t relu_dot(input vec_t vec, input int row);
		longint sum;
		sum = 64'sd0;
		for (int j = 0; j < nn_pkg::num_inputs; j++) begin
			sum += longint'(vec[j]) * longint'(nn_pkg::weights[row][j]);
		end
		if (sum < 64'sd0) begin
			return '0;
		end
		if (sum > 64'sd32767) begin
			return 16'sd32767;
		end
		return nn_pkg::data_t'(sum);
	endfunction

	function automatic int rand_below(input int limit);
		int r;
		r = $random(seed) & 32'h7fffffff;
		return r % limit;
	endfunction

	task automatic make_random(output vec_t vec);
		for (int j = 0; j < nn_pkg::num_inputs; j++) begin
			vec[j] = nn_pkg::data_t'($random(seed));
		end
	endtask

	// Called and returns 1 ns after a rising edge
	task automatic send_word(input nn_pkg::data_t value, input int gap);
		int waited;
		bit accepted;
		waited = 0;
		accepted = 1'b0;
		input_valid = 1'b0;
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
		input_valid = 1'b1;
		input_data = value;
		while (!accepted) begin
			@(negedge clk);
			accepted = input_ready;
			@(posedge clk);
			#1;
			waited++;
			if (!accepted && waited >= wait_limit) begin
				fail_with("Timeout waiting for input_ready");
			end
		end
		input_valid = 1'b0;
	endtask

	task automatic send_vector(input vec_t vec, input int max_gap);
		int gap;
		for (int r = 0; r < nn_pkg::num_outputs; r++) begin
			expected_q.push_back(relu_dot(vec, r));
		end
		for (int j = 0; j < nn_pkg::num_inputs; j++) begin
			gap = (max_gap > 0) ? rand_below(max_gap + 1) : 0;
			send_word(vec[j], gap);
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (expected_q.size() != 0) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited >= wait_limit) begin
				fail_with($sformatf("Timeout waiting for %0d outstanding outputs",
					expected_q.size()));
			end
		end
	endtask

	// Sink with optional random stalls
	initial begin
		output_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (stall_mode) begin
				output_ready = (($random(ready_seed) & 3) != 0);
			end else begin
				output_ready = 1'b1;
			end
		end
	end

	// Compare every output transfer, sampled mid-cycle
	initial begin : monitor
		nn_pkg::data_t expected;
		forever begin
			@(negedge clk);
			if (!reset && output_valid && output_ready) begin
				if (expected_q.size() == 0) begin
					fail_with("Output transfer seen with no expected value left");
				end
				expected = expected_q.pop_front();
				check_data(expected, output_data, $sformatf("%s row %0d", test_name,
					out_count % nn_pkg::num_outputs));
				out_count++;
			end
		end
	end

	initial begin
		vec_t vec;
		reset = 1'b1;
		input_valid = 1'b0;
		input_data = '0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		test_name = "reset";
		@(negedge clk);
		check_flag(1'b1, input_ready, "reset input_ready");
		check_flag(1'b0, output_valid, "reset output_valid");
		@(posedge clk);
		#1;

		test_name = "single";
		make_random(vec);
		send_vector(vec, 0);
		wait_drain();

		// Gaps on the input side and stalls on the output side
		test_name = "stream";
		stall_mode = 1'b1;
		repeat (10) begin
			make_random(vec);
			send_vector(vec, 3);
		end
		wait_drain();
		stall_mode = 1'b0;

		// Rows 0, 1, 2, 4 and 6 go negative here
		test_name = "relu";
		vec = '{16'sd100, 16'sd200, 16'sd300, 16'sd400};
		send_vector(vec, 0);
		wait_drain();

		test_name = "clip";
		vec = '{16'sd32767, 16'sd32767, 16'sd32767, 16'sd32767};
		send_vector(vec, 0);
		vec = '{-16'sd32767, -16'sd32767, -16'sd32767, -16'sd32767};
		send_vector(vec, 0);
		wait_drain();

		// Back to loading once the last row has left
		test_name = "idle";
		check_flag(1'b1, input_ready, "idle input_ready");
		check_flag(1'b0, output_valid, "idle output_valid");
		repeat (4) @(posedge clk);
		$display("No errors");
		$finish;
	end

endmodule

// ==== fc_layer_assert.sv ====
`timescale 1ns/1ps

module fc_layer_assert (
	input  logic clk,
	input  logic reset,
	input  logic input_ready,
	input  logic output_valid,
	input  logic output_ready,
	input  nn_pkg::data_t output_data
);

	// Result and valid stay put while the sink stalls
	property hold_on_stall;
		@(posedge clk) disable iff (reset)
		(output_valid && !output_ready) |=> (output_valid && $stable(output_data));
	endproperty

	// Loading and emitting never overlap
	property no_load_while_emit;
		@(posedge clk) !(input_ready && output_valid);
	endproperty

	property idle_after_reset;
		@(posedge clk) reset |=> !output_valid;
	endproperty

	assert property (hold_on_stall)
		else $error("output_data or output_valid changed under back-pressure");
	assert property (no_load_while_emit)
		else $error("input_ready and output_valid high in the same cycle");
	assert property (idle_after_reset)
		else $error("output_valid high in the cycle after reset");

endmodule

bind fc_layer fc_layer_assert i_fc_layer_assert (
	.clk(clk),
	.reset(reset),
	.input_ready(input_ready),
	.output_valid(output_valid),
	.output_ready(output_ready),
	.output_data(output_data)
);

// ==== fc_layer.sv ====
`timescale 1ns/1ps

module fc_layer (
	input  logic clk,
	input  logic reset,
	input  logic input_valid,
	output logic input_ready,
	input  nn_pkg::data_t input_data,
	output logic output_valid,
	input  logic output_ready,
	output nn_pkg::data_t output_data
);

	nn_pkg::mac_ctrl_t mac_ctrl;
	logic buf_write;
	logic [nn_pkg::x_addr_width-1:0] buf_waddr;
	logic [nn_pkg::lane_sel_width-1:0] lane_sel;
	nn_pkg::data_t x_out;
	nn_pkg::data_t lane_weight [nn_pkg::num_lanes];
	nn_pkg::data_t lane_result [nn_pkg::num_lanes];

	fc_control i_fc_control (
		.clk(clk),
		.reset(reset),
		.input_valid(input_valid),
		.input_ready(input_ready),
		.output_valid(output_valid),
		.output_ready(output_ready),
		.buf_write(buf_write),
		.buf_waddr(buf_waddr),
		.mac_ctrl(mac_ctrl),
		.lane_sel(lane_sel)
	);

	input_buffer i_input_buffer (
		.clk(clk),
		.buf_write(buf_write),
		.buf_waddr(buf_waddr),
		.input_data(input_data),
		.mac_ctrl(mac_ctrl),
		.x_out(x_out)
	);

	// All lanes share the x word, each has its own weights
	for (genvar p = 0; p < nn_pkg::num_lanes; p++) begin : g_lane
		weight_rom #(.lane(p)) i_weight_rom (
			.clk(clk),
			.mac_ctrl(mac_ctrl),
			.weight(lane_weight[p])
		);

		mac_lane i_mac_lane (
			.clk(clk),
			.reset(reset),
			.mac_ctrl(mac_ctrl),
			.x_in(x_out),
			.weight(lane_weight[p]),
			.result(lane_result[p])
		);
	end

	assign output_data = lane_result[lane_sel];

endmodule

// ==== fc_control.sv ====
`timescale 1ns/1ps

module fc_control (
	input  logic clk,
	input  logic reset,
	input  logic input_valid,
	output logic input_ready,
	output logic output_valid,
	input  logic output_ready,
	output logic buf_write,
	output logic [nn_pkg::x_addr_width-1:0] buf_waddr,
	output nn_pkg::mac_ctrl_t mac_ctrl,
	output logic [nn_pkg::lane_sel_width-1:0] lane_sel
);

	nn_pkg::fc_state_t state;
	logic [nn_pkg::x_addr_width-1:0] in_idx;
	logic [nn_pkg::group_width-1:0] group;
	logic fin_cnt;
	logic input_fire;
	logic output_fire;

	assign input_ready = (state == nn_pkg::load_input);
	assign output_valid = (state == nn_pkg::emit);

	assign input_fire = input_valid && input_ready;
	assign output_fire = output_valid && output_ready;

	// Buffer write follows the input index
	assign buf_write = input_fire;
	assign buf_waddr = in_idx;

	always_comb begin
		mac_ctrl.x_addr = in_idx;
		mac_ctrl.w_addr = {group, in_idx};
		mac_ctrl.enable = (state == nn_pkg::accumulate);
		// New sum on the first input of every group
		mac_ctrl.clear = (state == nn_pkg::accumulate) && (in_idx == '0);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= nn_pkg::load_input;
			in_idx <= '0;
			group <= '0;
			fin_cnt <= 1'b0;
			lane_sel <= '0;
		end else begin
			case (state)
				nn_pkg::load_input: begin
					if (input_fire) begin
						if (in_idx == nn_pkg::last_input) begin
							in_idx <= '0;
							group <= '0;
							state <= nn_pkg::accumulate;
						end else begin
							in_idx <= in_idx + 1'b1;
						end
					end
				end

				nn_pkg::accumulate: begin
					if (in_idx == nn_pkg::last_input) begin
						in_idx <= '0;
						fin_cnt <= 1'b0;
						state <= nn_pkg::finish;
					end else begin
						in_idx <= in_idx + 1'b1;
					end
				end

				// ROM and lane pipeline drain
				nn_pkg::finish: begin
					fin_cnt <= 1'b1;
					if (fin_cnt) begin
						lane_sel <= '0;
						state <= nn_pkg::emit;
					end
				end

				nn_pkg::emit: begin
					if (output_fire) begin
						if (lane_sel == nn_pkg::last_lane) begin
							lane_sel <= '0;
							if (group == nn_pkg::last_group) begin
								group <= '0;
								state <= nn_pkg::load_input;
							end else begin
								group <= group + 1'b1;
								state <= nn_pkg::accumulate;
							end
						end else begin
							lane_sel <= lane_sel + 1'b1;
						end
					end
				end

				default: begin
					state <= nn_pkg::load_input;
				end
			endcase
		end
	end

endmodule

// ==== mac_lane.sv ====
`timescale 1ns/1ps

module mac_lane (
	input  logic clk,
	input  logic reset,
	input  nn_pkg::mac_ctrl_t mac_ctrl,
	input  nn_pkg::data_t x_in,
	input  nn_pkg::data_t weight,
	output nn_pkg::data_t result
);

	logic clear_d;
	logic enable_d;
	nn_pkg::data_t x_d;
	nn_pkg::acc_t product;
	nn_pkg::acc_t acc;

	// Line up controls and x with the ROM output
	always_ff @(posedge clk) begin
		if (reset) begin
			clear_d <= 1'b0;
			enable_d <= 1'b0;
		end else begin
			clear_d <= mac_ctrl.clear;
			enable_d <= mac_ctrl.enable;
		end
	end

	always_ff @(posedge clk) begin
		x_d <= x_in;
	end

	assign product = nn_pkg::acc_t'(x_d) * nn_pkg::acc_t'(weight);

	// First product of a row reloads the sum
	always_ff @(posedge clk) begin
		if (enable_d) begin
			if (clear_d) begin
				acc <= product;
			end else begin
				acc <= acc + product;
			end
		end
	end

	// ReLU then clip to the word range
	always_comb begin
		if (acc < 0) begin
			result = '0;
		end else if (acc > nn_pkg::acc_t'(nn_pkg::data_max)) begin
			result = nn_pkg::data_max;
		end else begin
			result = nn_pkg::data_t'(acc);
		end
	end

endmodule

// ==== weight_rom.sv ====
`timescale 1ns/1ps

module weight_rom #(
	parameter int lane = 0
) (
	input  logic clk,
	input  nn_pkg::mac_ctrl_t mac_ctrl,
	output nn_pkg::data_t weight
);

	nn_pkg::data_t values [nn_pkg::num_groups * nn_pkg::num_inputs];

	// Entry g*N+j holds row g*P+lane, column j
	for (genvar a = 0; a < nn_pkg::num_groups * nn_pkg::num_inputs; a++) begin : g_entry
		assign values[a] =
			nn_pkg::weights[(a / nn_pkg::num_inputs) * nn_pkg::num_lanes + lane]
				[a % nn_pkg::num_inputs];
	end

	// Registered read, one cycle of latency
	always_ff @(posedge clk) begin
		weight <= values[mac_ctrl.w_addr];
	end

endmodule

// ==== input_buffer.sv ====
`timescale 1ns/1ps

module input_buffer (
	input  logic clk,
	input  logic buf_write,
	input  logic [nn_pkg::x_addr_width-1:0] buf_waddr,
	input  nn_pkg::data_t input_data,
	input  nn_pkg::mac_ctrl_t mac_ctrl,
	output nn_pkg::data_t x_out
);

	// One word per input of the vector
	nn_pkg::data_t mem [nn_pkg::num_inputs];

	always_ff @(posedge clk) begin
		if (buf_write) begin
			mem[buf_waddr] <= input_data;
		end
	end

	// Read path is combinational
	assign x_out = mem[mac_ctrl.x_addr];

endmodule

// ==== nn_pkg.sv ====
package nn_pkg;

	// Layer dimensions
	localparam int data_width = 16;
	localparam int acc_width = 40;
	localparam int num_inputs = 4;
	localparam int num_outputs = 8;
	localparam int num_lanes = 2;
	localparam int num_groups = num_outputs / num_lanes;

	localparam int x_addr_width = 2;
	localparam int w_addr_width = 4;
	localparam int lane_sel_width = 1;
	// Upper bits of a ROM address select the group
	localparam int group_width = w_addr_width - x_addr_width;

	typedef logic signed [data_width-1:0] data_t;
	typedef logic signed [acc_width-1:0] acc_t;

	// Largest positive output word
	localparam data_t data_max = data_t'((1 << (data_width - 1)) - 1);

	// Terminal counts for the control counters
	localparam logic [x_addr_width-1:0] last_input = x_addr_width'(num_inputs - 1);
	localparam logic [group_width-1:0] last_group = group_width'(num_groups - 1);
	localparam logic [lane_sel_width-1:0] last_lane = lane_sel_width'(num_lanes - 1);

	// Row r holds the weights of output r, column j applies to input j
	localparam data_t weights [num_outputs][num_inputs] = '{
		'{-16'sd1, -16'sd1, -16'sd2, -16'sd2},
		'{ 16'sd4, -16'sd1, -16'sd6, -16'sd2},
		'{ 16'sd6, -16'sd7,  16'sd4, -16'sd2},
		'{-16'sd6,  16'sd5, -16'sd1,  16'sd0},
		'{-16'sd7,  16'sd6, -16'sd7, -16'sd6},
		'{ 16'sd2,  16'sd7,  16'sd1,  16'sd1},
		'{-16'sd4, -16'sd3, -16'sd6,  16'sd6},
		'{-16'sd4,  16'sd1, -16'sd3,  16'sd3}
	};

	typedef enum logic [1:0] {
		load_input,
		accumulate,
		finish,
		emit
	} fc_state_t;

	// Control word shared by the buffer, ROMs and lanes
	typedef struct packed {
		logic [x_addr_width-1:0] x_addr;
		logic [w_addr_width-1:0] w_addr;
		logic clear;
		logic enable;
	} mac_ctrl_t;

endpackage
